//--- async_fifo.f
+incdir+src
src/afifo_pkg.sv
src/dualport_ram.sv
src/afifo_wr_ctrl.sv
src/afifo_rd_ctrl.sv
src/async_fifo.sv
testbench/tb_clk_gen.sv
testbench/tb_async_fifo.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the async FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f async_fifo.f \
  --top-module tb_async_fifo -o tb_async_fifo
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_async_fifo)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi

//--- src/afifo_config.svh
`ifndef AFIFO_CONFIG_SVH
`define AFIFO_CONFIG_SVH

// Width of one data word
`define AFIFO_DATA_WIDTH 8

// Number of entries, must be a power of two
`define AFIFO_DEPTH 16

// Write-side used count at which afull rises
`define AFIFO_AFULL 15

// Read-side used count at or below which aempty is high
`define AFIFO_AEMPTY 1

// Flops in each pointer synchronizer
`define AFIFO_SYNC_STAGES 2

// Extra top bit tells a full FIFO from an empty one
`define AFIFO_PTR_WIDTH ($clog2(`AFIFO_DEPTH) + 1)

`endif

//--- src/afifo_pkg.sv
`default_nettype none

`include "afifo_config.svh"

package afifo_pkg;

  typedef struct packed {
    logic                        wrap;
    logic [`AFIFO_PTR_WIDTH-2:0] addr;
  } ptr_t;

  typedef struct packed {
    logic full;
    logic afull;
  } wr_status_t;

  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_status_t;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return ptr_t'(bin ^ (bin >> 1));
  endfunction

  // Each binary bit is the XOR of all Gray bits at and above it
  function automatic ptr_t gray2bin(input ptr_t gray);
    logic [$bits(ptr_t)-1:0] g;
    logic [$bits(ptr_t)-1:0] b;
    g = gray;
    b[$bits(ptr_t)-1] = g[$bits(ptr_t)-1];
    for (int i = $bits(ptr_t) - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return ptr_t'(b);
  endfunction

endpackage

`default_nettype wire

//--- src/afifo_rd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "afifo_config.svh"

module afifo_rd_ctrl (
  input  wire logic                        rd_clk,
  input  wire logic                        rd_rst_n,
  input  wire logic                        rd_en,
  input  wire afifo_pkg::ptr_t             wr_gray,
  output logic                             ram_re,
  output logic [`AFIFO_PTR_WIDTH-2:0]      ram_raddr,
  output afifo_pkg::ptr_t                  rd_gray,
  output afifo_pkg::rd_status_t            rd_status
);

  localparam int PTR_W = $bits(afifo_pkg::ptr_t);

  logic                  rd_acc;
  afifo_pkg::ptr_t       rd_bin;
  afifo_pkg::ptr_t       rd_bin_nxt;
  afifo_pkg::ptr_t       rd_gray_nxt;
  afifo_pkg::ptr_t       wr_bin_sync;
  afifo_pkg::ptr_t       wr_sync [`AFIFO_SYNC_STAGES];
  logic [PTR_W-1:0]      used_nxt;

  assign rd_acc      = rd_en && !rd_status.empty;
  assign rd_bin_nxt  = rd_acc ? afifo_pkg::ptr_t'(rd_bin + 1'b1) : rd_bin;
  assign rd_gray_nxt = afifo_pkg::bin2gray(rd_bin_nxt);

  assign ram_re    = rd_acc;
  assign ram_raddr = rd_bin.addr;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
    end
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      for (int i = 0; i < `AFIFO_SYNC_STAGES; i++) begin
        wr_sync[i] <= '0;
      end
    end else begin
      wr_sync[0] <= wr_gray;
      for (int i = 1; i < `AFIFO_SYNC_STAGES; i++) begin
        wr_sync[i] <= wr_sync[i-1];
      end
    end
  end

  assign wr_bin_sync = afifo_pkg::gray2bin(wr_sync[`AFIFO_SYNC_STAGES-1]);

  // Lagging write pointer makes this a lower bound, so empty stays safe
  assign used_nxt = wr_bin_sync - rd_bin_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_status <= '1;
    end else begin
      rd_status.empty  <= (rd_bin_nxt == wr_bin_sync);
      rd_status.aempty <= (used_nxt <= PTR_W'(`AFIFO_AEMPTY));
    end
  end

  // Every RAM read must find a word that the synced write pointer has passed
  a_no_read_when_empty : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    ram_re |-> (rd_bin != wr_bin_sync)
  ) else $error("afifo_rd_ctrl: RAM read while empty");

  a_rd_gray_one_bit : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    $countones(rd_gray ^ $past(rd_gray)) <= 1
  ) else $error("afifo_rd_ctrl: read Gray pointer changed more than one bit");

endmodule

`default_nettype wire

//--- src/afifo_wr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "afifo_config.svh"

module afifo_wr_ctrl (
  input  wire logic                        wr_clk,
  input  wire logic                        wr_rst_n,
  input  wire logic                        wr_en,
  input  wire afifo_pkg::ptr_t             rd_gray,
  output logic                             ram_we,
  output logic [`AFIFO_PTR_WIDTH-2:0]      ram_waddr,
  output afifo_pkg::ptr_t                  wr_gray,
  output afifo_pkg::wr_status_t            wr_status
);

  localparam int PTR_W = $bits(afifo_pkg::ptr_t);

  logic                  wr_acc;
  afifo_pkg::ptr_t       wr_bin;
  afifo_pkg::ptr_t       wr_bin_nxt;
  afifo_pkg::ptr_t       wr_gray_nxt;
  afifo_pkg::ptr_t       rd_bin_sync;
  afifo_pkg::ptr_t       rd_sync [`AFIFO_SYNC_STAGES];
  logic [PTR_W-1:0]      used_nxt;

  assign wr_acc      = wr_en && !wr_status.full;
  assign wr_bin_nxt  = wr_acc ? afifo_pkg::ptr_t'(wr_bin + 1'b1) : wr_bin;
  assign wr_gray_nxt = afifo_pkg::bin2gray(wr_bin_nxt);

  assign ram_we    = wr_acc;
  assign ram_waddr = wr_bin.addr;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt;
    end
  end

  // Read pointer crosses in Gray code so only one bit can be in flight
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      for (int i = 0; i < `AFIFO_SYNC_STAGES; i++) begin
        rd_sync[i] <= '0;
      end
    end else begin
      rd_sync[0] <= rd_gray;
      for (int i = 1; i < `AFIFO_SYNC_STAGES; i++) begin
        rd_sync[i] <= rd_sync[i-1];
      end
    end
  end

  assign rd_bin_sync = afifo_pkg::gray2bin(rd_sync[`AFIFO_SYNC_STAGES-1]);

  // Stale read pointer makes the count an upper bound
  assign used_nxt = wr_bin_nxt - rd_bin_sync;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_status <= '0;
    end else begin
      wr_status.full  <= (used_nxt == PTR_W'(`AFIFO_DEPTH));
      wr_status.afull <= (used_nxt >= PTR_W'(`AFIFO_AFULL));
    end
  end

  // The registered full flag must still leave a free entry for every RAM write
  a_no_write_when_full : assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    ram_we |-> (PTR_W'(wr_bin - rd_bin_sync) < PTR_W'(`AFIFO_DEPTH))
  ) else $error("afifo_wr_ctrl: RAM write while full");

  a_wr_gray_one_bit : assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_gray ^ $past(wr_gray)) <= 1
  ) else $error("afifo_wr_ctrl: write Gray pointer changed more than one bit");

endmodule

`default_nettype wire

//--- src/async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "afifo_config.svh"

module async_fifo #(
  parameter int DATA_WIDTH = `AFIFO_DATA_WIDTH,
  parameter int FIFO_DEPTH = `AFIFO_DEPTH
) (
  input  wire logic                  wr_clk,
  input  wire logic                  wr_rst_n,
  input  wire logic                  wr_en,
  input  wire logic [DATA_WIDTH-1:0] wr_data,
  input  wire logic                  rd_clk,
  input  wire logic                  rd_rst_n,
  input  wire logic                  rd_en,
  output logic      [DATA_WIDTH-1:0] rd_data,
  output logic                       full,
  output logic                       afull,
  output logic                       empty,
  output logic                       aempty
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  // Pointer structs are sized from the config header, so depth must agree
  if (FIFO_DEPTH != `AFIFO_DEPTH) begin : g_depth_check
    $error("async_fifo: FIFO_DEPTH must equal AFIFO_DEPTH");
  end

  afifo_pkg::ptr_t       wr_gray;
  afifo_pkg::ptr_t       rd_gray;
  afifo_pkg::wr_status_t wr_status;
  afifo_pkg::rd_status_t rd_status;
  logic                  ram_we;
  logic                  ram_re;
  logic [ADDR_WIDTH-1:0] ram_waddr;
  logic [ADDR_WIDTH-1:0] ram_raddr;

  afifo_wr_ctrl u_wr_ctrl (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_en     (wr_en),
    .rd_gray   (rd_gray),
    .ram_we    (ram_we),
    .ram_waddr (ram_waddr),
    .wr_gray   (wr_gray),
    .wr_status (wr_status)
  );

  afifo_rd_ctrl u_rd_ctrl (
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_en     (rd_en),
    .wr_gray   (wr_gray),
    .ram_re    (ram_re),
    .ram_raddr (ram_raddr),
    .rd_gray   (rd_gray),
    .rd_status (rd_status)
  );

  dualport_ram #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_ram (
    .wr_clk    (wr_clk),
    .ram_we    (ram_we),
    .ram_waddr (ram_waddr),
    .ram_wdata (wr_data),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .ram_re    (ram_re),
    .ram_raddr (ram_raddr),
    .ram_rdata (rd_data)
  );

  assign full   = wr_status.full;
  assign afull  = wr_status.afull;
  assign empty  = rd_status.empty;
  assign aempty = rd_status.aempty;

endmodule

`default_nettype wire

//--- src/dualport_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dualport_ram #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 4
) (
  input  wire logic                  wr_clk,
  input  wire logic                  ram_we,
  input  wire logic [ADDR_WIDTH-1:0] ram_waddr,
  input  wire logic [DATA_WIDTH-1:0] ram_wdata,
  input  wire logic                  rd_clk,
  input  wire logic                  rd_rst_n,
  input  wire logic                  ram_re,
  input  wire logic [ADDR_WIDTH-1:0] ram_raddr,
  output logic      [DATA_WIDTH-1:0] ram_rdata
);

  localparam int RAM_DEPTH = 1 << ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [RAM_DEPTH];

  always_ff @(posedge wr_clk) begin
    if (ram_we) begin
      mem[ram_waddr] <= ram_wdata;
    end
  end

  // Output register holds the last word read until the next read
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      ram_rdata <= '0;
    end else if (ram_re) begin
      ram_rdata <= mem[ram_raddr];
    end
  end

  // A write with an unknown address would corrupt an unpredictable entry
  a_waddr_known : assert property (
    @(posedge wr_clk) ram_we |-> !$isunknown(ram_waddr)
  ) else $error("dualport_ram: write with unknown address");

  a_raddr_known : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    ram_re |-> !$isunknown(ram_raddr)
  ) else $error("dualport_ram: read with unknown address");

endmodule

`default_nettype wire

//--- testbench/afifo_cases.txt
# Command, then hex values: W data | R expected rd_data | S idle rd_clk cycles
# F expected full afull empty aempty | X cycles of random traffic
F 0 0 1 1
R 00
W 11
S 8
F 0 0 0 1
W 22
S 8
F 0 0 0 0
W 33
W 44
W 55
W 66
W 77
W 88
W 99
W AA
W BB
W CC
W DD
W EE
S 8
F 0 0 0 0
W FF
S 8
F 0 1 0 0
W 10
S 8
F 1 1 0 0
# Dropped because the FIFO is full
W 5A
R 11
R 22
R 33
R 44
R 55
R 66
R 77
R 88
R 99
R AA
R BB
R CC
R DD
R EE
R FF
R 10
S 8
F 0 0 1 1
# Read while empty keeps the last word
R 10
W 3C
S 8
R 3C
X 190
F 0 0 1 1

//--- testbench/tb_async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "afifo_config.svh"

module tb_async_fifo;

  localparam int DW = `AFIFO_DATA_WIDTH;

  typedef struct packed {
    logic [7:0]  cmd;
    logic [31:0] arg;
    logic [3:0]  flags;
  } case_t;

  logic          wr_clk;
  logic          rd_clk;
  logic          wr_rst_n;
  logic          rd_rst_n;
  logic          wr_en;
  logic          rd_en;
  logic [DW-1:0] wr_data;
  logic [DW-1:0] rd_data;
  logic          full;
  logic          afull;
  logic          empty;
  logic          aempty;

  case_t         cases[$];
  logic [DW-1:0] model_q[$];
  logic          rd_pending;
  logic [DW-1:0] rd_expect;
  int            seed;
  int            errors;
  int            cycle_count;
  int            cycle_limit;

  tb_clk_gen #(.PERIOD_NS(28)) u_wr_clk_gen (.clk(wr_clk));
  tb_clk_gen #(.PERIOD_NS(40)) u_rd_clk_gen (.clk(rd_clk));

  async_fifo u_dut (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  task automatic report_failure(input string why);
    errors++;
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Full only moves on wr_clk edges, so its value here decides the next edge
  task automatic write_step(input logic want, input logic [DW-1:0] data);
    @(posedge wr_clk);
    #2;
    wr_en   = want;
    wr_data = data;
    if (want && !full) begin
      model_q.push_back(data);
    end
  endtask

  // Checks the word taken on the previous edge, then decides the next read
  task automatic read_step(input logic want);
    @(posedge rd_clk);
    #2;
    if (rd_pending) begin
      check_equal("rd_data", 32'(rd_data), 32'(rd_expect));
      rd_pending = 1'b0;
    end
    rd_en = want;
    if (want && !empty) begin
      if (model_q.size() == 0) begin
        report_failure("DUT accepted a read while the model held no data");
      end else begin
        rd_expect  = model_q.pop_front();
        rd_pending = 1'b1;
      end
    end
  endtask

  task automatic read_word(input logic [31:0] exp);
    read_step(1'b1);
    read_step(1'b0);
    check_equal("rd_data", 32'(rd_data), exp);
  endtask

  task automatic check_flags(input logic [3:0] exp);
    @(posedge wr_clk);
    #2;
    check_equal("full", 32'(full), 32'(exp[3]));
    check_equal("afull", 32'(afull), 32'(exp[2]));
    @(posedge rd_clk);
    #2;
    check_equal("empty", 32'(empty), 32'(exp[1]));
    check_equal("aempty", 32'(aempty), 32'(exp[0]));
  endtask

  task automatic random_writer(input int n);
    int r;
    repeat (n) begin
      r = $random(seed);
      write_step(r[0], r[DW+7:8]);
    end
    write_step(1'b0, '0);
  endtask

  task automatic random_reader(input int n);
    int r;
    repeat (n) begin
      r = $random(seed);
      read_step(r[1:0] != 2'b00);
    end
    read_step(1'b0);
  endtask

  task automatic random_traffic(input int n);
    fork
      random_writer(n);
      random_reader(n);
    join
    while (model_q.size() > 0) begin
      read_step(1'b1);
    end
    read_step(1'b0);
    repeat (8) @(posedge rd_clk);
    #2;
    check_equal("empty", 32'(empty), 32'd1);
  endtask

  task automatic load_cases();
    int    fd;
    int    n;
    int    f0;
    int    f1;
    int    f2;
    int    f3;
    int    x_total;
    byte   c;
    string rest;
    case_t entry;
    x_total = 0;
    fd = $fopen("testbench/afifo_cases.txt", "r");
    if (fd == 0) begin
      report_failure("could not open testbench/afifo_cases.txt");
    end else begin
      while ($fscanf(fd, " %c", c) == 1) begin
        entry     = '0;
        entry.cmd = c;
        if (c == "#") begin
          n = $fgets(rest, fd);
        end else if (c == "F") begin
          n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
          entry.flags = {f0[0], f1[0], f2[0], f3[0]};
          if (n != 4) begin
            report_failure("a flag line in the cases file has fewer than four values");
          end else begin
            cases.push_back(entry);
          end
        end else begin
          n = $fscanf(fd, "%h", f0);
          entry.arg = f0;
          if (n != 1) begin
            report_failure("a command in the cases file has no value");
          end else begin
            cases.push_back(entry);
          end
          if (c == "X") begin
            x_total += f0;
          end
        end
      end
      $fclose(fd);
      cycle_limit = cases.size() * 40 + x_total * 4;
    end
  endtask

  task automatic run_case(input case_t c);
    case (c.cmd)
      "W": begin
        write_step(1'b1, c.arg[DW-1:0]);
        write_step(1'b0, '0);
      end
      "R": read_word(c.arg);
      "S": repeat (c.arg) @(posedge rd_clk);
      "F": check_flags(c.flags);
      "X": random_traffic(c.arg);
      default: report_failure("the cases file holds an unknown command");
    endcase
  endtask

  always @(posedge rd_clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      report_failure($sformatf("timeout, the cases did not finish in %0d rd_clk cycles",
                               cycle_limit));
    end
  end

  initial begin
    seed        = 94;
    errors      = 0;
    cycle_count = 0;
    cycle_limit = 0;
    rd_pending  = 1'b0;
    rd_expect   = '0;
    wr_rst_n    = 1'b0;
    rd_rst_n    = 1'b0;
    wr_en       = 1'b0;
    rd_en       = 1'b0;
    wr_data     = '0;
    load_cases();
    fork
      begin
        repeat (5) @(posedge wr_clk);
        #2;
        wr_rst_n = 1'b1;
      end
      begin
        repeat (5) @(posedge rd_clk);
        #2;
        rd_rst_n = 1'b1;
      end
    join
    check_equal("rd_data", 32'(rd_data), 32'h0);
    foreach (cases[i]) begin
      run_case(cases[i]);
    end
    if (errors == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      report_failure("checks failed during the run");
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  // Starts low so the first rising edge lands half a period in
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

endmodule

`default_nettype wire
